// ==== Makefile ====
# Verilator build and run of the vector unit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module vec_unit_tb -Mdir obj_dir -f vec_unit.f
	@out="$$(./obj_dir/Vvec_unit_tb)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== src/vec_alu.sv ====
// Vector ALU
// Element-wise integer ops at SEW 8/16/32 with v0 masking and tail
// undisturbed, plus vmv.x.s and the vsetvli result
`timescale 1ns/100ps
`default_nettype none

module vec_alu #(
    parameter int VLEN = 128
) (
    input  wire vec_pkg::exe_ctrl_t exe_ctrl,
    input  wire logic [VLEN-1:0]    vs1_data,
    input  wire logic [VLEN-1:0]    vs2_data,
    input  wire logic [VLEN-1:0]    vd_data,
    input  wire logic [VLEN-1:0]    v0_mask,
    input  wire vec_pkg::xdata_t    vl,
    input  wire vec_pkg::vtype_t    vtype,
    input  wire logic               clear_pipe,
    output logic                    vrf_wr_en,
    output logic [4:0]              vrf_wr_addr,
    output logic [VLEN-1:0]         vrf_wr_data,
    output logic                    cfg_wr,
    output vec_pkg::xdata_t         avl,
    output vec_pkg::vtype_t         new_vtype,
    output vec_pkg::xdata_t         int_result,
    output logic                    int_wr
);
    import vec_pkg::*;

    // Upper bound on element count, reached at SEW8
    localparam int NELEM = VLEN / 8;

    xdata_t     elem_res [NELEM];
    logic       elem_act [NELEM];
    logic [2:0] sew_lg;
    logic       go;
    logic       is_mvxs;

    function automatic xdata_t sext(xdata_t v, sew_e sew);
        case (sew)
            SEW8:    return {{24{v[7]}}, v[7:0]};
            SEW16:   return {{16{v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

    // Element width in bits as a shift
    assign sew_lg = 3'd3 + {1'b0, vtype.sew};

    always_comb begin
        xdata_t a;
        xdata_t b;
        xdata_t sh;
        int     idx;
        int     part;
        // Operands kept sign-extended so one 32-bit compare serves both orders
        for (int i = 0; i < NELEM; i++) begin
            a = sext(xdata_t'(vs2_data >> (i << sew_lg)), vtype.sew);
            case (exe_ctrl.src_sel)
                VX:      b = sext(exe_ctrl.scalar, vtype.sew);
                VI:      b = sext({{27{exe_ctrl.imm[4]}}, exe_ctrl.imm}, vtype.sew);
                default: b = sext(xdata_t'(vs1_data >> (i << sew_lg)), vtype.sew);
            endcase
            sh = b & ((xdata_t'(8) << vtype.sew) - xdata_t'(1));
            case (exe_ctrl.op)
                ADD:     elem_res[i] = a + b;
                SUB:     elem_res[i] = a - b;
                MIN:     elem_res[i] = ($signed(a) < $signed(b)) ? a : b;
                MINU:    elem_res[i] = (a < b) ? a : b;
                MAX:     elem_res[i] = ($signed(a) > $signed(b)) ? a : b;
                MAXU:    elem_res[i] = (a > b) ? a : b;
                AND:     elem_res[i] = a & b;
                OR:      elem_res[i] = a | b;
                XOR:     elem_res[i] = a ^ b;
                SLL:     elem_res[i] = a << sh;
                default: elem_res[i] = a;
            endcase
            elem_act[i] = (32'(i) < vl) && (exe_ctrl.vm || v0_mask[i]);
        end
        // Byte lane j belongs to element j >> sew
        for (int j = 0; j < NELEM; j++) begin
            idx  = j >> vtype.sew;
            part = j & ((1 << vtype.sew) - 1);
            vrf_wr_data[j*8 +: 8] = elem_act[idx] ? elem_res[idx][part*8 +: 8]
                                                  : vd_data[j*8 +: 8];
        end
    end

    assign go      = exe_ctrl.valid && !clear_pipe;
    assign is_mvxs = !exe_ctrl.is_cfg && (exe_ctrl.op == MVXS);

    assign vrf_wr_en   = go && !exe_ctrl.is_cfg && !is_mvxs;
    assign vrf_wr_addr = exe_ctrl.vd;
    assign cfg_wr      = go && exe_ctrl.is_cfg;
    assign avl         = exe_ctrl.scalar;
    assign new_vtype   = exe_ctrl.vtype;
    assign int_wr      = go && (exe_ctrl.is_cfg || is_mvxs);
    assign int_result  = exe_ctrl.is_cfg ? calc_vl(exe_ctrl.scalar, exe_ctrl.vtype, VLEN)
                                         : sext(vs2_data[31:0], vtype.sew);

    always_comb begin
        if (!$isunknown({vrf_wr_en, cfg_wr})) begin
            assert (!(vrf_wr_en && cfg_wr))
                else $error("vector write and vsetvli in the same cycle");
        end
    end

endmodule

`default_nettype wire

// ==== src/vec_csr.sv ====
// Vector configuration state
// Holds vl and vtype, updated only by vsetvli
`timescale 1ns/100ps
`default_nettype none

module vec_csr #(
    parameter int VLEN = 128
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            cfg_wr,
    input  wire vec_pkg::xdata_t avl,
    input  wire vec_pkg::vtype_t new_vtype,
    output vec_pkg::xdata_t      vl,
    output vec_pkg::vtype_t      vtype
);
    import vec_pkg::*;

    localparam vtype_t VTYPE_ILL = '{vill: 1'b1, sew: SEW8};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vl    <= '0;
            vtype <= VTYPE_ILL;
        end else if (cfg_wr) begin
            vl <= calc_vl(avl, new_vtype, VLEN);
            // Reserved SEW leaves vill set with a clean SEW field
            if (new_vtype.vill) begin
                vtype <= VTYPE_ILL;
            end else begin
                vtype <= new_vtype;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        vl <= xdata_t'(VLEN / 8))
        else $error("vl above VLEN/8");

endmodule

`default_nettype wire

// ==== src/vec_decode.sv ====
// Vector decode stage
// Decodes OP-V instructions, drives register file read addresses and
// holds the decode-to-execute control register
`timescale 1ns/100ps
`default_nettype none

module vec_decode (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             instr_valid,
    input  wire vec_pkg::vinstr_u instr,
    input  wire vec_pkg::xdata_t  int_rf_rd_data,
    input  wire logic             clear_pipe,
    input  wire vec_pkg::vtype_t  vtype,
    output logic [4:0]            rs_vs1,
    output logic [4:0]            rs_vs2,
    output logic [4:0]            rs_vd,
    output vec_pkg::exe_ctrl_t    exe_ctrl,
    output logic                  illegal_instr
);
    import vec_pkg::*;

    exe_ctrl_t dec;
    logic      legal;
    logic      arith;
    logic      cur_vill;

    assign rs_vs1 = instr.opv.vs1;
    assign rs_vs2 = instr.opv.vs2;
    assign rs_vd  = instr.opv.vd;

    // vsetvli in execute decides vill for the instruction behind it
    assign cur_vill = (exe_ctrl.valid && exe_ctrl.is_cfg && !clear_pipe) ?
                      exe_ctrl.vtype.vill : vtype.vill;

    always_comb begin
        dec        = '0;
        legal      = 1'b0;
        arith      = 1'b0;
        dec.vm     = instr.opv.vm;
        dec.vd     = instr.opv.vd;
        dec.imm    = instr.opv.vs1;
        dec.scalar = int_rf_rd_data;
        // vsew sits in zimm[5:3]
        dec.vtype.sew  = sew_e'(instr.cfg.zimm[4:3]);
        dec.vtype.vill = instr.cfg.zimm[5] || (instr.cfg.zimm[4:3] == 2'b11);

        if (instr.opv.opcode == OPC_OPV) begin
            case (instr.opv.funct3)
                F3_OPCFG: begin
                    dec.is_cfg = 1'b1;
                    legal      = !instr.cfg.bit31;
                end
                F3_OPIVV, F3_OPIVX, F3_OPIVI: begin
                    arith = 1'b1;
                    legal = 1'b1;
                    case (instr.opv.funct6)
                        F6_ADD:  dec.op = ADD;
                        F6_SUB:  dec.op = SUB;
                        F6_MINU: dec.op = MINU;
                        F6_MIN:  dec.op = MIN;
                        F6_MAXU: dec.op = MAXU;
                        F6_MAX:  dec.op = MAX;
                        F6_AND:  dec.op = AND;
                        F6_OR:   dec.op = OR;
                        F6_XOR:  dec.op = XOR;
                        F6_SLL:  dec.op = SLL;
                        default: legal = 1'b0;
                    endcase
                    case (instr.opv.funct3)
                        F3_OPIVX: dec.src_sel = VX;
                        F3_OPIVI: dec.src_sel = VI;
                        default:  dec.src_sel = VV;
                    endcase
                end
                F3_OPMVV: begin
                    // vmv.x.s
                    dec.op = MVXS;
                    legal  = (instr.opv.funct6 == F6_WXUNARY0) && (instr.opv.vs1 == 5'd0);
                end
                default: legal = 1'b0;
            endcase
        end

        if (arith && cur_vill) begin
            legal = 1'b0;
        end
        dec.valid = instr_valid && legal && !clear_pipe;
    end

    always_ff @(posedge clk) begin
        exe_ctrl <= dec;
        if (!rst_n) begin
            exe_ctrl.valid <= 1'b0;
            illegal_instr  <= 1'b0;
        end else begin
            illegal_instr <= instr_valid && !legal && !clear_pipe;
        end
    end

    // An illegal instruction never reaches execute
    assert property (@(posedge clk) disable iff (!rst_n)
        illegal_instr |-> !exe_ctrl.valid)
        else $error("illegal instruction entered execute");

endmodule

`default_nettype wire

// ==== src/vec_pkg.sv ====
// Vector unit shared definitions
// Scalar word, vtype, instruction views, RVV encodings and the execute control word
`default_nettype none

package vec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xdata_t;

    // Code 3 is reserved and treated as illegal
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_e;

    typedef struct packed {
        logic vill;
        sew_e sew;
    } vtype_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        MIN,
        MINU,
        MAX,
        MAXU,
        AND,
        OR,
        XOR,
        SLL,
        MVXS
    } valu_op_e;

    typedef enum logic [1:0] {
        VV,
        VX,
        VI
    } src_sel_e;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } opv_fmt_t;

    typedef struct packed {
        logic        bit31;
        logic [10:0] zimm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } cfg_fmt_t;

    // Same OP-V word, arithmetic view or vsetvli view
    typedef union packed {
        opv_fmt_t opv;
        cfg_fmt_t cfg;
    } vinstr_u;

    typedef struct packed {
        logic     valid;
        logic     is_cfg;
        valu_op_e op;
        src_sel_e src_sel;
        logic     vm;
        logic [4:0] vd;
        logic [4:0] imm;
        xdata_t   scalar;
        vtype_t   vtype;
    } exe_ctrl_t;

    localparam logic [6:0] OPC_OPV = 7'b1010111;

    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPMVV = 3'b010;
    localparam logic [2:0] F3_OPIVI = 3'b011;
    localparam logic [2:0] F3_OPIVX = 3'b100;
    localparam logic [2:0] F3_OPCFG = 3'b111;

    localparam logic [5:0] F6_ADD      = 6'b000000;
    localparam logic [5:0] F6_SUB      = 6'b000010;
    localparam logic [5:0] F6_MINU     = 6'b000100;
    localparam logic [5:0] F6_MIN      = 6'b000101;
    localparam logic [5:0] F6_MAXU     = 6'b000110;
    localparam logic [5:0] F6_MAX      = 6'b000111;
    localparam logic [5:0] F6_AND      = 6'b001001;
    localparam logic [5:0] F6_OR       = 6'b001010;
    localparam logic [5:0] F6_XOR      = 6'b001011;
    localparam logic [5:0] F6_SLL      = 6'b100101;
    localparam logic [5:0] F6_WXUNARY0 = 6'b010000;

    // New vl for vsetvli, min(avl, VLMAX), zero when vill
    function automatic xdata_t calc_vl(xdata_t avl, vtype_t vt, int vlen);
        xdata_t vlmax;
        case (vt.sew)
            SEW16:   vlmax = xdata_t'(vlen / 16);
            SEW32:   vlmax = xdata_t'(vlen / 32);
            default: vlmax = xdata_t'(vlen / 8);
        endcase
        if (vt.vill) begin
            return '0;
        end
        return (avl < vlmax) ? avl : vlmax;
    endfunction

endpackage

`default_nettype wire

// ==== src/vec_regfile.sv ====
// Vector register file
// 32 x VLEN registers, registered operand reads with write-through
// forwarding, v0 mask port and a combinational debug port
`timescale 1ns/100ps
`default_nettype none

module vec_regfile #(
    parameter int VLEN = 128
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic [4:0]      rs_vs1,
    input  wire logic [4:0]      rs_vs2,
    input  wire logic [4:0]      rs_vd,
    input  wire logic [4:0]      dbg_addr,
    input  wire logic            wr_en,
    input  wire logic [4:0]      wr_addr,
    input  wire logic [VLEN-1:0] wr_data,
    output logic [VLEN-1:0]      vs1_data,
    output logic [VLEN-1:0]      vs2_data,
    output logic [VLEN-1:0]      vd_data,
    output logic [VLEN-1:0]      v0_mask,
    output logic [VLEN-1:0]      dbg_data
);

    logic [VLEN-1:0] regs [32];

    // Read in decode, new value wins when execute writes the same register
    function automatic logic [VLEN-1:0] fwd_read(logic [4:0] addr);
        return (wr_en && wr_addr == addr) ? wr_data : regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Operand registers for execute
    always_ff @(posedge clk) begin
        vs1_data <= fwd_read(rs_vs1);
        vs2_data <= fwd_read(rs_vs2);
        vd_data  <= fwd_read(rs_vd);
        v0_mask  <= fwd_read(5'd0);
    end

    assign dbg_data = regs[dbg_addr];

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr))
        else $error("vector write with unknown address");

endmodule

`default_nettype wire

// ==== src/vec_unit.sv ====
// Vector unit top level
// Decode and execute/writeback stages around the vector register file,
// vl/vtype state and the ALU, with a registered scalar writeback
`timescale 1ns/100ps
`default_nettype none

module vec_unit #(
    parameter int VLEN = 128
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             instr_valid,
    input  wire vec_pkg::vinstr_u instr,
    input  wire vec_pkg::xdata_t  int_rf_rd_data,
    input  wire logic             clear_pipe,
    output logic                  int_rf_wr_en,
    output vec_pkg::xdata_t       int_rf_wr_data,
    output logic                  illegal_instr,
    input  wire logic [4:0]       dbg_addr,
    output logic [VLEN-1:0]       dbg_data
);
    import vec_pkg::*;

    logic [4:0]      rs_vs1;
    logic [4:0]      rs_vs2;
    logic [4:0]      rs_vd;
    exe_ctrl_t       exe_ctrl;
    vtype_t          vtype;
    xdata_t          vl;
    logic [VLEN-1:0] vs1_data;
    logic [VLEN-1:0] vs2_data;
    logic [VLEN-1:0] vd_data;
    logic [VLEN-1:0] v0_mask;
    logic            vrf_wr_en;
    logic [4:0]      vrf_wr_addr;
    logic [VLEN-1:0] vrf_wr_data;
    logic            cfg_wr;
    xdata_t          avl;
    vtype_t          new_vtype;
    xdata_t          int_result;
    logic            int_wr;

    vec_decode v_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .int_rf_rd_data (int_rf_rd_data),
        .clear_pipe     (clear_pipe),
        .vtype          (vtype),
        .rs_vs1         (rs_vs1),
        .rs_vs2         (rs_vs2),
        .rs_vd          (rs_vd),
        .exe_ctrl       (exe_ctrl),
        .illegal_instr  (illegal_instr)
    );

    vec_regfile #(.VLEN(VLEN)) v_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs_vs1   (rs_vs1),
        .rs_vs2   (rs_vs2),
        .rs_vd    (rs_vd),
        .dbg_addr (dbg_addr),
        .wr_en    (vrf_wr_en),
        .wr_addr  (vrf_wr_addr),
        .wr_data  (vrf_wr_data),
        .vs1_data (vs1_data),
        .vs2_data (vs2_data),
        .vd_data  (vd_data),
        .v0_mask  (v0_mask),
        .dbg_data (dbg_data)
    );

    vec_csr #(.VLEN(VLEN)) v_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .avl       (avl),
        .new_vtype (new_vtype),
        .vl        (vl),
        .vtype     (vtype)
    );

    vec_alu #(.VLEN(VLEN)) v_alu (
        .exe_ctrl    (exe_ctrl),
        .vs1_data    (vs1_data),
        .vs2_data    (vs2_data),
        .vd_data     (vd_data),
        .v0_mask     (v0_mask),
        .vl          (vl),
        .vtype       (vtype),
        .clear_pipe  (clear_pipe),
        .vrf_wr_en   (vrf_wr_en),
        .vrf_wr_addr (vrf_wr_addr),
        .vrf_wr_data (vrf_wr_data),
        .cfg_wr      (cfg_wr),
        .avl         (avl),
        .new_vtype   (new_vtype),
        .int_result  (int_result),
        .int_wr      (int_wr)
    );

    // Scalar writeback stage
    always_ff @(posedge clk) begin
        int_rf_wr_data <= int_result;
        if (!rst_n) begin
            int_rf_wr_en <= 1'b0;
        end else begin
            int_rf_wr_en <= int_wr;
        end
    end

endmodule

`default_nettype wire

// ==== vec_unit.f ====
src/vec_pkg.sv
src/vec_decode.sv
src/vec_regfile.sv
src/vec_csr.sv
src/vec_alu.sv
src/vec_unit.sv
verif/vec_unit_tb.sv

// ==== verif/vec_unit_tb.sv ====
// Vector unit testbench
// Drives OP-V instructions, tracks a shadow model and checks the DUT with assertions
`timescale 1ns/100ps
`default_nettype none

module vec_unit_tb;

    localparam int VLEN = 128;
    // About 400 cycles of tests, limit leaves ample margin
    localparam int MAX_CYCLES = 4000;
    localparam logic [6:0] OPV = 7'b1010111;

    typedef struct packed {
        logic            wb;
        logic [31:0]     wb_data;
        logic            ill;
        logic            chk;
        logic [4:0]      addr;
        logic [VLEN-1:0] val;
    } expect_t;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [31:0]     int_rf_rd_data;
    logic            clear_pipe;
    logic [4:0]      dbg_addr = '0;
    logic            int_rf_wr_en;
    logic [31:0]     int_rf_wr_data;
    logic            illegal_instr;
    logic [VLEN-1:0] dbg_data;

    // Shadow state
    logic [VLEN-1:0] m_vreg [32];
    int              m_vl;
    logic            m_vill;
    int              m_sew;

    expect_t exp_now;
    expect_t exp_d1;
    expect_t exp_d2;
    int      seed;
    int      errors = 0;
    int      tests_run = 0;
    int      cycles = 0;

    vec_unit #(.VLEN(VLEN)) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .int_rf_rd_data (int_rf_rd_data),
        .clear_pipe     (clear_pipe),
        .int_rf_wr_en   (int_rf_wr_en),
        .int_rf_wr_data (int_rf_wr_data),
        .illegal_instr  (illegal_instr),
        .dbg_addr       (dbg_addr),
        .dbg_data       (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Expectations follow the instruction down the pipe
    always @(posedge clk) begin
        exp_d1   <= exp_now;
        exp_d2   <= exp_d1;
        dbg_addr <= exp_d1.addr;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [VLEN-1:0] got,
                                   input logic [VLEN-1:0] want);
        errors++;
        $display("error at %0t: %s got %h expected %h", $time, what, got, want);
    endtask

    illegal_check: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_instr == exp_d1.ill)
        else report_mismatch("illegal_instr", VLEN'($sampled(illegal_instr)),
                             VLEN'($sampled(exp_d1.ill)));

    wb_en_check: assert property (@(posedge clk) disable iff (!rst_n)
        int_rf_wr_en == exp_d2.wb)
        else report_mismatch("int_rf_wr_en", VLEN'($sampled(int_rf_wr_en)),
                             VLEN'($sampled(exp_d2.wb)));

    wb_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        exp_d2.wb |-> int_rf_wr_data == exp_d2.wb_data)
        else report_mismatch("int_rf_wr_data", VLEN'($sampled(int_rf_wr_data)),
                             VLEN'($sampled(exp_d2.wb_data)));

    vreg_check: assert property (@(posedge clk) disable iff (!rst_n)
        exp_d2.chk |-> dbg_data == exp_d2.val)
        else report_mismatch("vector register", $sampled(dbg_data), $sampled(exp_d2.val));

    function automatic int rnd(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    function automatic logic [31:0] enc_vsetvli(input logic [2:0] vsew);
        return {1'b0, 5'b00000, vsew, 3'b000, 5'd1, 3'b111, 5'd1, OPV};
    endfunction

    function automatic logic [31:0] enc_opv(input logic [5:0] f6, input logic vm,
                                            input logic [4:0] vs2, input logic [4:0] src,
                                            input logic [2:0] f3, input logic [4:0] vd);
        return {f6, vm, vs2, src, f3, vd, OPV};
    endfunction

    // add sub minu min maxu max and or xor sll
    function automatic logic [5:0] op_funct6(input int op);
        case (op)
            0:       return 6'b000000;
            1:       return 6'b000010;
            2:       return 6'b000100;
            3:       return 6'b000101;
            4:       return 6'b000110;
            5:       return 6'b000111;
            6:       return 6'b001001;
            7:       return 6'b001010;
            8:       return 6'b001011;
            default: return 6'b100101;
        endcase
    endfunction

    function automatic logic [VLEN-1:0] ref_arith(input int op, input int form,
                                                  input logic [4:0] src, input logic [31:0] scalar,
                                                  input logic vm, input int vd, input int vs2);
        logic [VLEN-1:0]    res;
        logic [31:0]        mask;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        r;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        res  = m_vreg[vd];
        mask = 32'hffff_ffff >> (32 - m_sew);
        for (int i = 0; i < VLEN / m_sew; i++) begin
            a = 32'(m_vreg[vs2] >> (i * m_sew)) & mask;
            case (form)
                0:       b = 32'(m_vreg[src] >> (i * m_sew)) & mask;
                1:       b = scalar & mask;
                default: b = {{27{src[4]}}, src} & mask;
            endcase
            // Left-aligned copies order the elements as signed values
            sa = a << (32 - m_sew);
            sb = b << (32 - m_sew);
            case (op)
                0:       r = a + b;
                1:       r = a - b;
                2:       r = (a < b) ? a : b;
                3:       r = (sa < sb) ? a : b;
                4:       r = (a > b) ? a : b;
                5:       r = (sa > sb) ? a : b;
                6:       r = a & b;
                7:       r = a | b;
                8:       r = a ^ b;
                default: r = a << (b % m_sew);
            endcase
            if (i < m_vl && (vm || m_vreg[0][i])) begin
                for (int k = 0; k < m_sew; k++) begin
                    res[i * m_sew + k] = r[k];
                end
            end
        end
        return res;
    endfunction

    task automatic send(input logic [31:0] word, input logic [31:0] scalar, input expect_t e);
        @(posedge clk);
        instr_valid    <= 1'b1;
        instr          <= word;
        int_rf_rd_data <= scalar;
        clear_pipe     <= 1'b0;
        exp_now        <= e;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            clear_pipe  <= 1'b0;
            exp_now     <= '0;
        end
    endtask

    // Holds clear_pipe over the execute cycle of the last instruction sent
    task automatic kill_execute();
        @(posedge clk);
        instr_valid <= 1'b0;
        clear_pipe  <= 1'b1;
        exp_now     <= '0;
    endtask

    task automatic do_vsetvli(input logic [2:0] vsew, input logic [31:0] avl);
        expect_t e;
        int      vlmax;
        e = '0;
        if (vsew > 3'd2) begin
            m_vill = 1'b1;
            m_sew  = 8;
            m_vl   = 0;
        end else begin
            m_vill = 1'b0;
            m_sew  = 8 << vsew;
            vlmax  = VLEN / m_sew;
            m_vl   = (avl < vlmax) ? avl : vlmax;
        end
        e.wb      = 1'b1;
        e.wb_data = m_vl;
        send(enc_vsetvli(vsew), avl, e);
    endtask

    task automatic do_arith(input int op, input int form, input logic vm, input int vd,
                            input int vs2, input logic [4:0] src, input logic [31:0] scalar,
                            input bit kill);
        expect_t    e;
        logic [2:0] f3;
        e  = '0;
        f3 = (form == 0) ? 3'b000 : (form == 1) ? 3'b100 : 3'b011;
        e.ill  = m_vill;
        e.chk  = 1'b1;
        e.addr = 5'(vd);
        if (!m_vill && !kill) begin
            m_vreg[vd] = ref_arith(op, form, src, scalar, vm, vd, vs2);
        end
        e.val = m_vreg[vd];
        send(enc_opv(op_funct6(op), vm, 5'(vs2), src, f3, 5'(vd)), scalar, e);
        if (kill) begin
            kill_execute();
        end
    endtask

    task automatic do_vmvxs(input int vs2, input bit kill);
        expect_t     e;
        logic [31:0] w;
        e = '0;
        w = m_vreg[vs2][31:0] << (32 - m_sew);
        w = 32'($signed(w) >>> (32 - m_sew));
        e.wb      = !kill;
        e.wb_data = w;
        send(enc_opv(6'b010000, 1'b1, 5'(vs2), 5'd0, 3'b010, 5'd1), rnd32(), e);
        if (kill) begin
            kill_execute();
        end
    endtask

    task automatic do_bad(input int vd, input int vs2);
        expect_t e;
        e      = '0;
        e.ill  = 1'b1;
        e.chk  = 1'b1;
        e.addr = 5'(vd);
        e.val  = m_vreg[vd];
        send(enc_opv(6'b111000, 1'b1, 5'(vs2), 5'd3, 3'b000, 5'(vd)), rnd32(), e);
    endtask

    task automatic rand_arith(input logic vm);
        int form;
        form = rnd(0, 2);
        do_arith(rnd(0, 9), form, vm, rnd(1, 15), rnd(1, 15),
                 (form == 0) ? 5'(rnd(1, 15)) : 5'(rnd(0, 31)), rnd32(), 1'b0);
    endtask

    // Random 32-bit elements built up one vl step at a time
    task automatic fill_reg(input int r);
        for (int k = 1; k <= VLEN / 32; k++) begin
            do_vsetvli(3'd2, 32'(k));
            do_arith(0, 1, 1'b1, r, r, 5'd0, rnd32(), 1'b0);
        end
    endtask

    task automatic end_test(input string name);
        idle(4);
        tests_run++;
        $display("test %0d %s done, %0d errors so far", tests_run, name, errors);
    endtask

    task automatic test_vsetvli();
        int vlmax;
        for (int s = 0; s < 3; s++) begin
            vlmax = VLEN / (8 << s);
            do_vsetvli(3'(s), 32'd1);
            do_vsetvli(3'(s), 32'(vlmax - 1));
            do_vsetvli(3'(s), 32'(vlmax));
            do_vsetvli(3'(s), 32'(vlmax + 1 + rnd(0, 100)));
            do_vsetvli(3'(s), rnd32());
        end
        do_vsetvli(3'd3, rnd32());
        do_arith(0, 0, 1'b1, 5, 1, 5'd2, 32'd0, 1'b0);
        end_test("vsetvli");
    endtask

    task automatic test_arith();
        fill_reg(1);
        fill_reg(2);
        fill_reg(3);
        for (int s = 0; s < 3; s++) begin
            do_vsetvli(3'(s), 32'd64);
            for (int op = 0; op < 10; op++) begin
                for (int form = 0; form < 3; form++) begin
                    do_arith(op, form, 1'b1, rnd(4, 15), rnd(1, 15),
                             (form == 0) ? 5'(rnd(1, 15)) : 5'(rnd(0, 31)), rnd32(), 1'b0);
                    idle(1);
                end
            end
        end
        end_test("arithmetic");
    endtask

    task automatic test_mask();
        fill_reg(0);
        for (int s = 0; s < 3; s++) begin
            do_vsetvli(3'(s), 32'(rnd(1, VLEN / (8 << s) - 1)));
            repeat (6) begin
                rand_arith(1'b0);
                idle(1);
            end
        end
        end_test("masking and tail");
    endtask

    task automatic test_forward();
        int prev;
        int nd;
        for (int s = 0; s < 3; s++) begin
            do_vsetvli(3'(s), 32'd64);
            prev = rnd(1, 15);
            repeat (3) begin
                for (int k = 0; k < 4; k++) begin
                    nd = rnd(1, 15);
                    do_arith(rnd(0, 9), 0, 1'b1, nd, prev, 5'(rnd(1, 15)), rnd32(), 1'b0);
                    prev = nd;
                end
                idle(2);
            end
        end
        end_test("back-to-back forwarding");
    endtask

    task automatic test_mvxs_clear();
        for (int s = 0; s < 3; s++) begin
            do_vsetvli(3'(s), 32'd64);
            repeat (3) begin
                do_vmvxs(rnd(1, 15), 1'b0);
            end
        end
        idle(2);
        do_arith(rnd(0, 9), 0, 1'b1, rnd(1, 15), rnd(1, 15), 5'(rnd(1, 15)), rnd32(), 1'b1);
        idle(1);
        do_vmvxs(rnd(1, 15), 1'b1);
        idle(1);
        do_vmvxs(rnd(1, 15), 1'b0);
        end_test("vmv.x.s and clear_pipe");
    endtask

    task automatic test_illegal();
        do_vsetvli(3'd0, 32'd64);
        repeat (4) begin
            do_bad(rnd(0, 15), rnd(1, 15));
            idle(1);
        end
        end_test("unknown funct6");
    endtask

    initial begin
        seed = 32'haa86535f;
        for (int i = 0; i < 32; i++) begin
            m_vreg[i] = '0;
        end
        m_vl           = 0;
        m_vill         = 1'b1;
        m_sew          = 8;
        rst_n          <= 1'b0;
        instr_valid    <= 1'b0;
        instr          <= '0;
        int_rf_rd_data <= '0;
        clear_pipe     <= 1'b0;
        exp_now        <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_vsetvli();
        test_arith();
        test_mask();
        test_forward();
        test_mvxs_clear();
        test_illegal();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
